//--- list.f
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/id_decode.sv
rtl/stage_reg.sv
rtl/ex_alu.sv
rtl/int_core.sv
verif/int_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module int_core_tb \
    -Mdir obj_dir -o int_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/int_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

//--- verif/int_core_tb.sv
module int_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    typedef struct packed {
        logic        issue;
        logic [31:0] inst;
    } row_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [63:0] data;
        logic [63:0] pc;
        logic [31:0] due;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        inst_valid_i;
    logic [63:0] pc_i;
    logic [31:0] inst_i;
    logic        wb_valid_o;
    logic        wb_we_o;
    logic [4:0]  wb_waddr_o;
    logic [63:0] wb_wdata_o;
    logic [63:0] wb_pc_o;

    integer      seed = 82828;
    logic [31:0] cyc = 32'd0;
    row_t        table_q[$];
    exp_t        exp_q[$];
    logic [63:0] ref_regs [32];

    int_core int_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_waddr_o   (wb_waddr_o),
        .wb_wdata_o   (wb_wdata_o),
        .wb_pc_o      (wb_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 32'd1;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    // ======================================================================
    // instruction encoders
    // ======================================================================

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        r_type = {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        i_type = {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        u_type = {imm, rd, OPC_LUI};
    endfunction

    // one random LUI, register or immediate operation with the given registers
    function automatic logic [31:0] rand_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        rnd = $random(seed);
        f3  = rnd[5:3];
        alt = rnd[6] && ((f3 == 3'b000) || (f3 == 3'b101));
        case (rnd[2:0])
            3'd0: rand_inst = u_type(rnd[31:12], rd);
            3'd1, 3'd2, 3'd3: rand_inst = r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
            default: begin
                imm = rnd[31:20];
                if (f3 == 3'b001) begin
                    imm = {6'b0, rnd[25:20]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, rnd[6], 4'b0, rnd[25:20]};
                end
                rand_inst = i_type(imm, rs1, f3, rd);
            end
        endcase
    endfunction

    // ======================================================================
    // reference model
    // ======================================================================

    task automatic model_issue(input logic [31:0] inst, input logic [63:0] pc);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] res;
        logic        alt;
        logic        ok;
        exp_t        e;
        opc = inst[6:0];
        f3  = inst[14:12];
        f7  = inst[31:25];
        rd  = inst[11:7];
        a   = ref_regs[inst[19:15]];
        b   = ref_regs[inst[24:20]];
        res = 64'd0;
        ok  = 1'b1;
        alt = inst[30];
        if (opc == OPC_LUI) begin
            res = {{32{inst[31]}}, inst[31:12], 12'h000};
        end else if ((opc == OPC_OP) || (opc == OPC_OP_IMM)) begin
            if (opc == OPC_OP_IMM) begin
                b   = {{52{inst[31]}}, inst[31:20]};
                alt = inst[30] && (f3 == 3'b101);
            end else begin
                ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
            end
            case (f3)
                3'b000: begin
                    if ((opc == OPC_OP) && alt) res = a - b;
                    else res = a + b;
                end
                3'b001: res = a << b[5:0];
                3'b010: begin
                    if ($signed(a) < $signed(b)) res = 64'd1;
                end
                3'b011: begin
                    if (a < b) res = 64'd1;
                end
                3'b100: res = a ^ b;
                3'b101: begin
                    if (alt) res = $signed(a) >>> b[5:0];
                    else res = a >> b[5:0];
                end
                3'b110: res = a | b;
                default: res = a & b;
            endcase
        end else begin
            ok = 1'b0;
        end
        e.we    = ok && (rd != 5'd0);
        e.waddr = rd;
        e.data  = res;
        e.pc    = pc;
        e.due   = cyc + 32'd2;
        if (e.we) ref_regs[rd] = res;
        exp_q.push_back(e);
    endtask

    // ======================================================================
    // stimulus table
    // ======================================================================

    task automatic add_row(input logic issue, input logic [31:0] inst);
        row_t r;
        r.issue = issue;
        r.inst  = inst;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        // known values, negative ones and some with the top bit set
        add_row(1'b1, i_type(12'd5, 5'd0, 3'b000, 5'd1));
        add_row(1'b1, i_type(12'hffd, 5'd0, 3'b000, 5'd2));
        add_row(1'b1, i_type(12'h7ff, 5'd0, 3'b000, 5'd3));
        add_row(1'b1, u_type(20'h80000, 5'd4));
        add_row(1'b1, u_type(20'h12345, 5'd5));
        add_row(1'b1, i_type(12'hfff, 5'd0, 3'b000, 5'd6));
        add_row(1'b0, 32'h0);
        add_row(1'b1, i_type(12'd7, 5'd1, 3'b000, 5'd0));
        add_row(1'b1, i_type(12'd63, 5'd6, 3'b001, 5'd7));
        add_row(1'b1, i_type(12'h678, 5'd5, 3'b000, 5'd5));
        add_row(1'b0, 32'h0);
        // register-register operations
        add_row(1'b1, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd8));
        add_row(1'b1, r_type(7'h20, 5'd4, 5'd2, 3'b000, 5'd9));
        add_row(1'b1, r_type(7'h00, 5'd6, 5'd5, 3'b111, 5'd10));
        add_row(1'b1, r_type(7'h00, 5'd1, 5'd4, 3'b110, 5'd11));
        add_row(1'b1, r_type(7'h00, 5'd2, 5'd5, 3'b100, 5'd12));
        add_row(1'b1, r_type(7'h00, 5'd1, 5'd5, 3'b001, 5'd13));
        add_row(1'b1, r_type(7'h00, 5'd1, 5'd4, 3'b101, 5'd14));
        add_row(1'b1, r_type(7'h20, 5'd1, 5'd4, 3'b101, 5'd15));
        add_row(1'b1, r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd16));
        add_row(1'b1, r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd17));
        add_row(1'b1, r_type(7'h00, 5'd2, 5'd7, 3'b010, 5'd18));
        add_row(1'b1, r_type(7'h20, 5'd3, 5'd7, 3'b101, 5'd19));
        add_row(1'b1, r_type(7'h00, 5'd6, 5'd1, 3'b001, 5'd20));
        // immediate forms
        add_row(1'b1, i_type(12'hf9c, 5'd2, 3'b000, 5'd21));
        add_row(1'b1, i_type(12'h0f0, 5'd6, 3'b111, 5'd22));
        add_row(1'b1, i_type(12'hff0, 5'd1, 3'b110, 5'd23));
        add_row(1'b1, i_type(12'hfff, 5'd5, 3'b100, 5'd24));
        add_row(1'b1, i_type(12'hffe, 5'd2, 3'b010, 5'd25));
        add_row(1'b1, i_type(12'hfff, 5'd1, 3'b011, 5'd26));
        add_row(1'b1, i_type(12'd40, 5'd1, 3'b001, 5'd27));
        add_row(1'b1, i_type(12'd33, 5'd4, 3'b101, 5'd28));
        add_row(1'b1, i_type(12'h421, 5'd4, 3'b101, 5'd29));
        add_row(1'b1, i_type(12'h43f, 5'd7, 3'b101, 5'd30));
        add_row(1'b1, r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd31));
        // a load opcode and an XOR with SUB's funct7 must not write
        add_row(1'b1, {12'h004, 5'd1, 3'b011, 5'd8, 7'b0000011});
        add_row(1'b1, r_type(7'h20, 5'd2, 5'd1, 3'b100, 5'd9));
        add_row(1'b0, 32'h0);
        add_row(1'b1, r_type(7'h00, 5'd9, 5'd8, 3'b000, 5'd31));
        add_row(1'b1, r_type(7'h00, 5'd27, 5'd0, 3'b000, 5'd30));
        // consumers exactly two slots behind their producers
        add_row(1'b1, i_type(12'd100, 5'd0, 3'b000, 5'd1));
        add_row(1'b1, i_type(12'hff9, 5'd0, 3'b000, 5'd2));
        add_row(1'b1, r_type(7'h00, 5'd6, 5'd1, 3'b000, 5'd3));
        add_row(1'b1, r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
        add_row(1'b1, r_type(7'h20, 5'd1, 5'd3, 3'b101, 5'd5));
        prev2 = 5'd4;
        prev1 = 5'd5;
        for (int i = 0; i < 48; i++) begin
            rnd = $random(seed);
            rd  = (rnd[4:0] == 5'd0) ? 5'd3 : rnd[4:0];
            if (rd == prev1) rd = (rd == 5'd31) ? 5'd1 : rd + 5'd1;
            rs2 = (rnd[9:5] == prev1) ? prev2 : rnd[9:5];
            add_row(1'b1, rand_inst(rd, prev2, rs2));
            prev2 = prev1;
            prev1 = rd;
        end
    endtask

    // ======================================================================
    // writeback monitor
    // ======================================================================

    always @(negedge clk) begin
        exp_t e;
        if (!rst_n) begin
            if (wb_valid_o) begin
                assert (exp_q.size() != 0)
                else report_failure("a writeback appeared with no instruction outstanding");
                e = exp_q.pop_front();
                assert (cyc == e.due)
                else report_failure($sformatf("CHECK FAILED writeback cycle: got %h expected %h",
                                              cyc, e.due));
                assert (wb_pc_o == e.pc)
                else report_failure($sformatf("CHECK FAILED wb_pc_o: got %h expected %h",
                                              wb_pc_o, e.pc));
                assert (wb_we_o == e.we)
                else report_failure($sformatf("CHECK FAILED wb_we_o: got %h expected %h",
                                              wb_we_o, e.we));
                assert (wb_waddr_o == e.waddr)
                else report_failure($sformatf("CHECK FAILED wb_waddr_o: got %h expected %h",
                                              wb_waddr_o, e.waddr));
                if (e.we) begin
                    assert (wb_wdata_o == e.data)
                    else report_failure($sformatf("CHECK FAILED wb_wdata_o: got %h expected %h",
                                                  wb_wdata_o, e.data));
                end
            end else if (exp_q.size() != 0) begin
                assert (exp_q[0].due > cyc)
                else report_failure("an issued instruction gave no writeback when it was due");
            end
        end
    end

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        logic [63:0] pc_val;
        int          wait_cnt;
        rst_n        = 1'b1;
        inst_valid_i = 1'b0;
        pc_i         = 64'd0;
        inst_i       = 32'd0;
        pc_val       = 64'h0000_0000_8000_0000;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = 64'd0;
        end
        build_table();

        repeat (10) @(posedge clk);
        #1 rst_n = 1'b0;

        repeat (3) begin
            @(negedge clk);
            assert (wb_valid_o == 1'b0)
            else report_failure($sformatf("CHECK FAILED wb_valid_o: got %h expected %h",
                                          wb_valid_o, 1'b0));
            assert (wb_we_o == 1'b0)
            else report_failure($sformatf("CHECK FAILED wb_we_o: got %h expected %h",
                                          wb_we_o, 1'b0));
        end

        foreach (table_q[i]) begin
            @(posedge clk);
            #1;
            pc_i = pc_val;
            if (table_q[i].issue) begin
                inst_valid_i = 1'b1;
                inst_i       = table_q[i].inst;
                model_issue(table_q[i].inst, pc_val);
            end else begin
                inst_valid_i = 1'b0;
                inst_i       = 32'd0;
            end
            pc_val = pc_val + 64'd4;
        end
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
        inst_i       = 32'd0;

        wait_cnt = 0;
        while ((exp_q.size() != 0) && (wait_cnt < 20)) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            report_failure("timed out waiting for outstanding writebacks");
        end else begin
            // idle cycles give the monitor a chance to see a stray writeback
            repeat (4) @(negedge clk);
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

//--- rtl/int_core.sv
module int_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_valid_i,
    input  logic [rv_pkg::xlen-1:0] pc_i,
    input  logic [31:0]             inst_i,
    output logic                    wb_valid_o,
    output logic                    wb_we_o,
    output logic [4:0]              wb_waddr_o,
    output logic [rv_pkg::xlen-1:0] wb_wdata_o,
    output logic [rv_pkg::xlen-1:0] wb_pc_o
);
    import rv_pkg::*;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    id_ex_t id_ex_d;
    id_ex_t id_ex_q;
    ex_wb_t ex_wb_d;
    ex_wb_t ex_wb_q;

    // ======================================================================
    // decode and register read
    // ======================================================================

    id_decode u_id_decode (
        .inst_valid_i (inst_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .id_ex_o      (id_ex_d)
    );

    // write port is fed straight from the EX/WB register
    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (ex_wb_q.valid && ex_wb_q.reg_we),
        .waddr_i    (ex_wb_q.reg_waddr),
        .wdata_i    (ex_wb_q.wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .d_i   (id_ex_d),
        .q_o   (id_ex_q)
    );

    // ======================================================================
    // execute and writeback
    // ======================================================================

    ex_alu u_ex_alu (
        .id_ex_i (id_ex_q),
        .ex_wb_o (ex_wb_d)
    );

    stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .d_i   (ex_wb_d),
        .q_o   (ex_wb_q)
    );

    assign wb_valid_o = ex_wb_q.valid;
    assign wb_we_o    = ex_wb_q.reg_we;
    assign wb_waddr_o = ex_wb_q.reg_waddr;
    assign wb_wdata_o = ex_wb_q.wdata;
    assign wb_pc_o    = ex_wb_q.pc;

endmodule

//--- rtl/ex_alu.sv
module ex_alu (
    input  rv_pkg::id_ex_t id_ex_i,
    output rv_pkg::ex_wb_t ex_wb_o
);
    import rv_pkg::*;

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [5:0]      sh;
    logic [xlen-1:0] result;

    assign op1 = id_ex_i.op1;
    assign op2 = id_ex_i.op2;
    assign sh  = op2[5:0];

    // ======================================================================
    // result select
    // ======================================================================

    always_comb begin
        case (id_ex_i.alu_op)
            ADD:     result = op1 + op2;
            SUB:     result = op1 - op2;
            AND:     result = op1 & op2;
            OR:      result = op1 | op2;
            XOR:     result = op1 ^ op2;
            SLL:     result = op1 << sh;
            SRL:     result = op1 >> sh;
            SRA:     result = $signed(op1) >>> sh;
            SLT:     result = {{(xlen-1){1'b0}}, ($signed(op1) < $signed(op2))};
            SLTU:    result = {{(xlen-1){1'b0}}, (op1 < op2)};
            PASS_B:  result = op2;
            default: result = '0;
        endcase
    end

    // ======================================================================
    // writeback payload
    // ======================================================================

    always_comb begin
        ex_wb_o.valid     = id_ex_i.valid;
        ex_wb_o.pc        = id_ex_i.pc;
        ex_wb_o.reg_we    = id_ex_i.reg_we;
        ex_wb_o.reg_waddr = id_ex_i.reg_waddr;
        ex_wb_o.wdata     = result;
    end

    // decode only ever emits defined operations, an undefined code here
    // means the ID/EX register or the decoder went wrong
    always_comb begin
        if (id_ex_i.valid) begin
            a_alu_op_defined : assert #0 (id_ex_i.alu_op inside {
                ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B
            }) else $error("undefined ALU operation %0h", id_ex_i.alu_op);
        end
    end

endmodule

//--- rtl/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d_i,
    output payload_t q_o
);

    // loads every cycle, there is no stall or flush in this pipe
    always_ff @(posedge clk) begin
        if (rst_n) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

    // a reset cycle must leave the whole payload zero, valid included,
    // so nothing reaches the next stage until real input arrives
    a_clear_after_reset : assert property (
        @(posedge clk) rst_n |=> (q_o == '0)
    ) else $error("stage register not cleared after reset");

endmodule

//--- rtl/id_decode.sv
module id_decode (
    input  logic                    inst_valid_i,
    input  logic [rv_pkg::xlen-1:0] pc_i,
    input  logic [31:0]             inst_i,
    input  logic [rv_pkg::xlen-1:0] rs1_data_i,
    input  logic [rv_pkg::xlen-1:0] rs2_data_i,
    output logic [4:0]              rs1_addr_o,
    output logic [4:0]              rs2_addr_o,
    output rv_pkg::id_ex_t          id_ex_o
);
    import rv_pkg::*;

    // ======================================================================
    // instruction fields
    // ======================================================================

    logic [6:0]      opcode;
    logic [4:0]      rd;
    logic [2:0]      funct3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [6:0]      funct7;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] shamt;

    logic            is_op;
    logic            is_shift;
    logic            funct7_ok;
    logic            known;
    alu_op_e         base_op;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    assign imm_i = {{(xlen-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {{(xlen-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    // RV64 shift amounts are six bits, taking bit 25 from the funct7 field
    assign shamt = {{(xlen-6){1'b0}}, inst_i[25:20]};

    assign is_op    = (opcode == OPC_OP);
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // only ADD/SUB and SRL/SRA have an alternate funct7 encoding
    assign funct7_ok = (funct7 == 7'b0000000) ||
                       ((funct7 == 7'b0100000) &&
                        ((funct3 == 3'b000) || (funct3 == 3'b101)));

    // ======================================================================
    // ALU operation
    // ======================================================================

    always_comb begin
        case (funct3)
            3'b000:  base_op = (is_op && funct7[5]) ? SUB : ADD;
            3'b001:  base_op = SLL;
            3'b010:  base_op = SLT;
            3'b011:  base_op = SLTU;
            3'b100:  base_op = XOR;
            3'b101:  base_op = funct7[5] ? SRA : SRL;
            3'b110:  base_op = OR;
            default: base_op = AND;
        endcase
    end

    // ======================================================================
    // payload
    // ======================================================================

    always_comb begin
        id_ex_o.valid     = inst_valid_i;
        id_ex_o.pc        = pc_i;
        id_ex_o.alu_op    = ADD;
        id_ex_o.op1       = rs1_data_i;
        id_ex_o.op2       = rs2_data_i;
        id_ex_o.reg_waddr = rd;
        known             = 1'b0;

        case (opcode)
            OPC_OP: begin
                id_ex_o.alu_op = base_op;
                known          = funct7_ok;
            end
            OPC_OP_IMM: begin
                id_ex_o.alu_op = base_op;
                id_ex_o.op2    = is_shift ? shamt : imm_i;
                known          = 1'b1;
            end
            OPC_LUI: begin
                id_ex_o.alu_op = PASS_B;
                id_ex_o.op1    = '0;
                id_ex_o.op2    = imm_u;
                known          = 1'b1;
            end
            default: begin
                // unknown opcode still flows down the pipe, it just never writes
                known = 1'b0;
            end
        endcase

        id_ex_o.reg_we = known && (rd != 5'd0);
    end

endmodule

//--- rtl/reg_file.sv
module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1_addr_i,
    input  logic [4:0]              rs2_addr_i,
    input  logic                    we_i,
    input  logic [4:0]              waddr_i,
    input  logic [rv_pkg::xlen-1:0] wdata_i,
    output logic [rv_pkg::xlen-1:0] rs1_data_o,
    output logic [rv_pkg::xlen-1:0] rs2_data_o
);
    import rv_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // a read that hits the register being written this cycle gets the new data,
    // so a consumer two slots behind its producer sees the result
    assign rs1_data_o = (we_i && (waddr_i != 5'd0) && (waddr_i == rs1_addr_i)) ? wdata_i :
                        (rs1_addr_i == 5'd0) ? '0 :
                        regs[rs1_addr_i];

    assign rs2_data_o = (we_i && (waddr_i != 5'd0) && (waddr_i == rs2_addr_i)) ? wdata_i :
                        (rs2_addr_i == 5'd0) ? '0 :
                        regs[rs2_addr_i];

    // x0 must stay zero even while the writeback stage targets it
    a_x0_reads_zero : assert property (
        @(posedge clk) disable iff (rst_n)
        ((rs1_addr_i == 5'd0) -> (rs1_data_o == '0)) &&
        ((rs2_addr_i == 5'd0) -> (rs2_data_o == '0))
    ) else $error("register x0 read returned a nonzero value");

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

    // ======================================================================
    // datapath width
    // ======================================================================

    localparam int xlen = 64;

    // ======================================================================
    // major opcodes handled by the integer datapath
    // ======================================================================

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ======================================================================
    // ALU operations
    // ======================================================================

    // PASS_B forwards operand two unchanged, which is how LUI gets its value
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    // ======================================================================
    // stage payloads
    // ======================================================================

    // decode to execute
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        alu_op_e         alu_op;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        logic            reg_we;
        logic [4:0]      reg_waddr;
    } id_ex_t;

    // execute to writeback
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            reg_we;
        logic [4:0]      reg_waddr;
        logic [xlen-1:0] wdata;
    } ex_wb_t;

endpackage
